// File: Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module zx_core_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_zx_core -Mdir obj_dir
	./obj_dir/Vtb_zx_core | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_zx_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_core import zx_pkg::*; ();

	// Eight audio runs of about 530 cycles dominate, paging and turbo add a few hundred
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int AUDIO_WINDOW   = 512;
	// All-RAM banks per configuration, quadrant 0 first
	localparam int SPECIAL_BANKS [16] = '{0, 1, 2, 3, 4, 5, 6, 7, 4, 5, 6, 3, 4, 7, 6, 3};

	logic              clk_sys;
	logic              reset;
	logic [MODE_W-1:0] machine_mode;
	logic [2:0]        turbo_sel;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] cpu_dout;
	logic              mreq;
	logic              iorq;
	logic              rd;
	logic              wr;
	logic              m1;
	logic              tape_in;
	logic              ce_cpu;
	logic [17:0]       mem_addr;
	logic              mem_we;
	logic [2:0]        border_color;
	logic              scr_page;
	logic              audio;

	int                seed;
	int                cycles;
	int                checks;
	int                errors;
	int                test_errors;
	// Reference model of the paging state
	logic [MODE_W-1:0] cur_mode;
	logic [7:0]        p7;
	logic [7:0]        p1;

	zx_core_top UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine_mode (machine_mode),
		.turbo_sel    (turbo_sel),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.mreq         (mreq),
		.iorq         (iorq),
		.rd           (rd),
		.wr           (wr),
		.m1           (m1),
		.tape_in      (tape_in),
		.ce_cpu       (ce_cpu),
		.mem_addr     (mem_addr),
		.mem_we       (mem_we),
		.border_color (border_color),
		.scr_page     (scr_page),
		.audio        (audio)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, DUT never finished", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// ==========================================================
	// Helpers
	// ==========================================================
	function automatic void note_mismatch(input string msg);
		errors = errors + 1;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endfunction

	// Bank expected in one quadrant from the paging rules
	function automatic int expected_bank(input int quad);
		int rom;
		if (cur_mode == MODE_PLUS3 && p1[0]) begin
			return SPECIAL_BANKS[int'(p1[2:1]) * 4 + quad];
		end
		case (cur_mode)
			MODE_128:   rom = int'(p7[4]);
			MODE_PLUS3: rom = int'({p1[2], p7[4]});
			default:    rom = 0;
		endcase
		case (quad)
			0:       return ROM_BANK_BASE + rom;
			1:       return 5;
			2:       return 2;
			default: return (cur_mode == MODE_48) ? 0 : int'(p7[2:0]);
		endcase
	endfunction

	task automatic apply_reset(input logic [MODE_W-1:0] mode);
		@(posedge clk_sys);
		reset <= 1'b1;
		machine_mode <= mode;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		checks++;
		assert (!ce_cpu && !audio && !mem_we && !scr_page)
			else note_mismatch("outputs not cleared during reset");
		@(posedge clk_sys);
		reset <= 1'b0;
		cur_mode = mode;
		p7 = 8'h00;
		p1 = 8'h00;
	endtask

	// I/O write held for three cycles, then one idle cycle
	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		addr <= a;
		cpu_dout <= d;
		iorq <= 1'b1;
		wr <= 1'b1;
		m1 <= 1'b0;
		repeat (3) @(posedge clk_sys);
		iorq <= 1'b0;
		wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic write_page_port(input logic [7:0] d);
		io_write(16'h7FFD, d);
		if (cur_mode != MODE_48 && !p7[5]) begin
			p7 = d;
		end
	endtask

	task automatic write_plus3_port(input logic [7:0] d);
		io_write(16'h1FFD, d);
		if (cur_mode == MODE_PLUS3 && !p7[5]) begin
			p1 = d;
		end
	endtask

	task automatic access_quadrant(input int quad, input logic do_write);
		logic [13:0] offset;
		int          bank;
		offset = 14'($random(seed));
		bank = expected_bank(quad);
		@(posedge clk_sys);
		addr <= {2'(quad), offset};
		mreq <= 1'b1;
		wr <= do_write;
		@(negedge clk_sys);
		checks += 2;
		assert (mem_addr == {4'(bank), offset})
			else note_mismatch($sformatf("quadrant %0d on bank %0d, expected %0d",
				quad, mem_addr[17:14], bank));
		assert (mem_we == (do_write && bank < ROM_BANK_BASE))
			else note_mismatch($sformatf("mem_we %0b on bank %0d", mem_we, bank));
		@(posedge clk_sys);
		mreq <= 1'b0;
		wr <= 1'b0;
	endtask

	task automatic check_map(input logic do_write);
		for (int q = 0; q < 4; q++) begin
			access_quadrant(q, do_write);
		end
	endtask

	task automatic check_scr_page();
		@(negedge clk_sys);
		checks++;
		assert (scr_page == p7[3])
			else note_mismatch($sformatf("scr_page %0b, expected %0b", scr_page, p7[3]));
	endtask

	task automatic measure_ce_gap(output int gap);
		@(negedge clk_sys);
		while (!ce_cpu) begin
			@(negedge clk_sys);
		end
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!ce_cpu);
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s done, %0d errors", num, name, errors - test_errors);
		test_errors = errors;
	endtask

	// ==========================================================
	// Bus properties
	// ==========================================================
	write_needs_bus: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |-> mreq && wr)
		else note_mismatch("mem_we without a memory write");
	rom_write_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |-> int'(mem_addr[17:14]) < ROM_BANK_BASE)
		else note_mismatch("mem_we raised on a ROM bank");

	// ==========================================================
	// Tests
	// ==========================================================
	initial begin
		int         gap;
		int         ones;
		int         level;
		logic [7:0] d;
		logic [2:0] old_border;
		seed = 32'h8eb9;
		cycles = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		clk_sys = 1'b0;
		reset <= 1'b1;
		machine_mode <= MODE_128;
		turbo_sel <= 3'd0;
		addr <= '0;
		cpu_dout <= '0;
		mreq <= 1'b0;
		iorq <= 1'b0;
		rd <= 1'b0;
		wr <= 1'b0;
		m1 <= 1'b0;
		tape_in <= 1'b0;

		apply_reset(MODE_128);
		for (int t = 0; t <= TURBO_MAX; t++) begin
			@(posedge clk_sys);
			turbo_sel <= 3'(t);
			// Divider wraps within 16 cycles
			repeat (20) @(posedge clk_sys);
			measure_ce_gap(gap);
			checks++;
			assert (gap == (1 << (4 - t)))
				else note_mismatch($sformatf("turbo %0d gap %0d", t, gap));
		end
		@(posedge clk_sys);
		turbo_sel <= 3'd0;
		end_test(1, "turbo rate");

		apply_reset(MODE_128);
		repeat (8) begin
			write_page_port(8'($random(seed)) & 8'hDF);
			check_map(1'b0);
			check_scr_page();
		end
		// Lock, then a write that must change nothing
		write_page_port(8'($random(seed)) | 8'h20);
		write_page_port(8'($random(seed)));
		check_map(1'b0);
		check_scr_page();
		apply_reset(MODE_128);
		check_map(1'b0);
		end_test(2, "128K paging");

		apply_reset(MODE_48);
		repeat (4) begin
			write_page_port(8'($random(seed)));
			write_plus3_port(8'h01);
			check_map(1'b0);
			check_scr_page();
		end
		end_test(3, "48K mode");

		apply_reset(MODE_PLUS3);
		for (int rom = 0; rom < 4; rom++) begin
			d = (8'($random(seed)) & 8'h0F) | ((rom % 2 == 1) ? 8'h10 : 8'h00);
			write_page_port(d);
			write_plus3_port((rom >= 2) ? 8'h04 : 8'h00);
			check_map(1'b0);
		end
		for (int cfg = 0; cfg < 4; cfg++) begin
			write_plus3_port(8'((cfg << 1) | 1));
			check_map(1'b0);
		end
		end_test(4, "+3 mode");

		apply_reset(MODE_128);
		check_map(1'b1);
		apply_reset(MODE_PLUS3);
		write_plus3_port(8'h03);
		check_map(1'b1);
		write_plus3_port(8'h00);
		check_map(1'b1);
		end_test(5, "write protect");

		repeat (4) begin
			d = 8'($random(seed));
			old_border = border_color;
			@(posedge clk_sys);
			addr <= 16'h00FE;
			cpu_dout <= d;
			iorq <= 1'b1;
			wr <= 1'b1;
			@(posedge clk_sys);
			@(negedge clk_sys);
			checks++;
			assert (old_border === d[2:0] || border_color === old_border)
				else note_mismatch("border changed one cycle early");
			@(posedge clk_sys);
			@(negedge clk_sys);
			checks++;
			assert (border_color == d[2:0])
				else note_mismatch($sformatf("border %0d, expected %0d", border_color, d[2:0]));
			@(posedge clk_sys);
			iorq <= 1'b0;
			wr <= 1'b0;
		end
		for (int c = 0; c < 8; c++) begin
			// EAR on data bit 4, MIC on bit 3
			io_write(16'h00FE, 8'((c & 6) << 2));
			tape_in <= 1'(c & 1);
			repeat (2) @(posedge clk_sys);
			ones = 0;
			repeat (AUDIO_WINDOW) begin
				@(negedge clk_sys);
				if (audio) begin
					ones++;
				end
			end
			level = 128 * ((c >> 2) & 1) + 64 * ((c >> 1) & 1) + 32 * (c & 1);
			checks++;
			assert (ones >= level - 1 && ones <= level + 1)
				else note_mismatch($sformatf("audio ones %0d, level %0d", ones, level));
		end
		tape_in <= 1'b0;
		end_test(6, "ULA port");

		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/clock_enables.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enables import zx_pkg::*; #(
	parameter int CE_DIV_W = 4
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [2:0] turbo_sel,
	output logic       ce_cpu
);

	logic [CE_DIV_W-1:0] div_cnt;
	logic [2:0]          turbo_q;
	logic [CE_DIV_W-1:0] ce_mask;
	logic                div_wrap;

	// Last count before the divider rolls over to zero
	assign div_wrap = &div_cnt;

	// Bits of the counter that must be all ones for a pulse
	assign ce_mask = {CE_DIV_W{1'b1}} >> turbo_q;

	// ==========================================================
	// Divider and turbo latch
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			turbo_q <= '0;
			ce_cpu  <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			// Masked-off bits forced high so only the low bits count
			ce_cpu  <= &(div_cnt | ~ce_mask);
			// New rate starts with the next period
			if (div_wrap) begin
				turbo_q <= turbo_sel;
			end
		end
	end

	// Rates above full speed have no meaning
	turbo_sel_range: assert property (
		@(posedge clk_sys) disable iff (reset)
		turbo_sel <= TURBO_MAX
	) else $error("turbo_sel %0d above TURBO_MAX", turbo_sel);

endmodule

`default_nettype wire

// File: hw/io_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Port-write strobes from the I/O decoder to the port registers
interface io_bus_if import zx_pkg::*; ();
	logic              ula_stb;
	logic              page_stb;
	logic              plus3_stb;
	logic [DATA_W-1:0] data;
	logic [MODE_W-1:0] mode;

	modport source (
		output ula_stb,
		output page_stb,
		output plus3_stb,
		output data,
		output mode
	);

	// Paging registers need the machine mode for their decode
	modport pager (
		input page_stb,
		input plus3_stb,
		input data,
		input mode
	);

	modport ula (
		input ula_stb,
		input data
	);
endinterface

`default_nettype wire

// File: hw/io_decode.sv
`timescale 1ns/1ps
`default_nettype none

module io_decode import zx_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [MODE_W-1:0] machine_mode,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              iorq,
	input  logic              wr,
	input  logic              m1,
	io_bus_if.source          bus
);

	logic              io_wr;
	logic              io_wr_q;
	logic              wr_edge;
	logic [MODE_W-1:0] mode_q;
	logic              ula_hit;
	logic              page_hit;
	logic              plus3_hit;

	// I/O write outside an interrupt acknowledge
	assign io_wr   = iorq & wr & ~m1;
	assign wr_edge = io_wr & ~io_wr_q;

	// ==========================================================
	// Partial port decode
	// ==========================================================
	// 0x7FFD is dead in 48 mode, +3 also looks at A14
	assign page_hit = (mode_q != MODE_48)
		& (addr[15] == PORT_7FFD[15]) & (addr[1] == PORT_7FFD[1])
		& ((addr[14] == PORT_7FFD[14]) | (mode_q != MODE_PLUS3));
	assign plus3_hit = (mode_q == MODE_PLUS3)
		& (addr[15:12] == PORT_1FFD[15:12]) & (addr[1] == PORT_1FFD[1]);
	// Overlap with the paging ports goes to the paging ports
	assign ula_hit = (addr[0] == PORT_FE[0]) & ~page_hit & ~plus3_hit;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q       <= 1'b0;
			bus.ula_stb   <= 1'b0;
			bus.page_stb  <= 1'b0;
			bus.plus3_stb <= 1'b0;
			mode_q        <= machine_mode;
		end else begin
			io_wr_q       <= io_wr;
			bus.ula_stb   <= wr_edge & ula_hit;
			bus.page_stb  <= wr_edge & page_hit;
			bus.plus3_stb <= wr_edge & plus3_hit;
		end
	end

	// Data byte travels alongside its strobe
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			bus.data <= cpu_dout;
		end
	end

	assign bus.mode = mode_q;

	single_strobe: assert property (
		@(posedge clk_sys) disable iff (reset)
		$onehot0({bus.ula_stb, bus.page_stb, bus.plus3_stb})
	) else $error("more than one port strobe in a cycle");

endmodule

`default_nettype wire

// File: hw/mem_map.sv
`timescale 1ns/1ps
`default_nettype none

module mem_map import zx_pkg::*; (
	input  logic                       mreq,
	input  logic                       wr,
	input  logic [ADDR_W-1:0]          addr,
	paging_if.sink                     map,
	output logic [BANK_W+OFFSET_W-1:0] mem_addr,
	output logic                       mem_we
);

	logic [1:0]        quad;
	logic [BANK_W-1:0] bank;
	logic              bank_is_ram;

	assign quad = addr[ADDR_W-1:OFFSET_W];

	// ==========================================================
	// Bank select per 16K quadrant
	// ==========================================================
	always_comb begin
		if (!map.special_en) begin
			case (quad)
				2'd0:    bank = BANK_W'(ROM_BANK_BASE) + BANK_W'(map.rom_sel);
				2'd1:    bank = BANK_W'(5);
				2'd2:    bank = BANK_W'(2);
				default: bank = BANK_W'(map.ram_page);
			endcase
		end else begin
			// All-RAM configs 0..3: 0123, 4567, 4563, 4763
			case (quad)
				2'd0:    bank = (map.special_cfg == 2'd0) ? BANK_W'(0) : BANK_W'(4);
				2'd1: begin
					if (map.special_cfg == 2'd0) begin
						bank = BANK_W'(1);
					end else if (map.special_cfg == 2'd3) begin
						bank = BANK_W'(7);
					end else begin
						bank = BANK_W'(5);
					end
				end
				2'd2:    bank = (map.special_cfg == 2'd0) ? BANK_W'(2) : BANK_W'(6);
				default: bank = (map.special_cfg == 2'd1) ? BANK_W'(7) : BANK_W'(3);
			endcase
		end
	end

	assign bank_is_ram = bank < BANK_W'(ROM_BANK_BASE);

	assign mem_addr = {bank, addr[OFFSET_W-1:0]};
	// ROM is write protected
	assign mem_we   = mreq & wr & bank_is_ram;

	// ROM only sits in the bottom quadrant outside all-RAM mode
	always_comb begin
		assert (!(mem_we && (quad == 2'd0) && !map.special_en))
			else $error("write strobe on ROM in quadrant 0");
	end

endmodule

`default_nettype wire

// File: hw/page_regs.sv
`timescale 1ns/1ps
`default_nettype none

module page_regs import zx_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	io_bus_if.pager  bus,
	paging_if.source map
);

	// Only the bits the paging logic looks at are kept
	logic [5:0] reg_7ffd;
	logic [2:0] reg_1ffd;
	logic       locked;

	// Bit 5 of 0x7FFD freezes paging until reset
	assign locked = reg_7ffd[5];

	// ==========================================================
	// Paging registers
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd <= '0;
			reg_1ffd <= '0;
		end else if (!locked) begin
			if (bus.page_stb) begin
				reg_7ffd <= bus.data[5:0];
			end
			if (bus.plus3_stb) begin
				reg_1ffd <= bus.data[2:0];
			end
		end
	end

	// ==========================================================
	// Decoded paging state
	// ==========================================================
	always_comb begin
		map.ram_page    = reg_7ffd[2:0];
		map.scr_page    = reg_7ffd[3];
		map.special_en  = reg_1ffd[0];
		map.special_cfg = reg_1ffd[2:1];

		case (bus.mode)
			MODE_128: begin
				map.rom_sel = {1'b0, reg_7ffd[4]};
			end
			MODE_PLUS3: begin
				// Four ROMs, high bit from 0x1FFD
				map.rom_sel = {reg_1ffd[2], reg_7ffd[4]};
			end
			default: begin
				map.rom_sel = 2'b00;
			end
		endcase

		// 48 machine keeps RAM 0 at the top
		if (bus.mode == MODE_48) begin
			map.ram_page = 3'd0;
		end
	end

	// 0x1FFD is decoded on the +3 only
	plus3_mode_only: assert property (
		@(posedge clk_sys) disable iff (reset)
		bus.plus3_stb |-> bus.mode == MODE_PLUS3
	) else $error("0x1FFD strobe outside +3 mode");

endmodule

`default_nettype wire

// File: hw/paging_if.sv
`timescale 1ns/1ps
`default_nettype none

// Paging state from the page registers to the address mapper
interface paging_if ();
	logic [2:0] ram_page;
	logic [1:0] rom_sel;
	logic       special_en;
	logic [1:0] special_cfg;
	logic       scr_page;

	modport source (
		output ram_page,
		output rom_sel,
		output special_en,
		output special_cfg,
		output scr_page
	);

	// Screen select goes to the video side, not to the mapper
	modport sink (
		input ram_page,
		input rom_sel,
		input special_en,
		input special_cfg
	);
endinterface

`default_nettype wire

// File: hw/ula_port_dac.sv
`timescale 1ns/1ps
`default_nettype none

module ula_port_dac #(
	parameter int DAC_W = 9
) (
	input  logic       clk_sys,
	input  logic       reset,
	io_bus_if.ula      bus,
	input  logic       tape_in,
	output logic [2:0] border_color,
	output logic       audio
);

	logic             ear;
	logic             mic;
	logic [DAC_W-1:0] level;
	logic [DAC_W-1:0] acc;
	logic [DAC_W:0]   acc_sum;

	// ==========================================================
	// Port 0xFE
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (bus.ula_stb) begin
			border_color <= bus.data[2:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear <= 1'b0;
			mic <= 1'b0;
		end else if (bus.ula_stb) begin
			ear <= bus.data[4];
			mic <= bus.data[3];
		end
	end

	// ==========================================================
	// Beeper DAC
	// ==========================================================
	// EAR loudest, then MIC, then tape
	assign level   = DAC_W'({ear, mic, tape_in, 5'b00000});
	assign acc_sum = {1'b0, acc} + {1'b0, level};

	// First order, carry out is the bitstream
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc   <= '0;
			audio <= 1'b0;
		end else begin
			acc   <= acc_sum[DAC_W-1:0];
			audio <= acc_sum[DAC_W];
		end
	end

endmodule

`default_nettype wire

// File: hw/zx_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_core_top import zx_pkg::*; #(
	parameter int CE_DIV_W = 4,
	parameter int DAC_W    = 9
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [MODE_W-1:0]          machine_mode,
	input  logic [2:0]                 turbo_sel,
	input  logic [ADDR_W-1:0]          addr,
	input  logic [DATA_W-1:0]          cpu_dout,
	input  logic                       mreq,
	input  logic                       iorq,
	// Kept for a complete Z80 bus, no reads are decoded here
	input  logic                       rd,
	input  logic                       wr,
	input  logic                       m1,
	input  logic                       tape_in,
	output logic                       ce_cpu,
	output logic [BANK_W+OFFSET_W-1:0] mem_addr,
	output logic                       mem_we,
	output logic [2:0]                 border_color,
	output logic                       scr_page,
	output logic                       audio
);

	io_bus_if io_bus ();
	paging_if paging ();

	// ==========================================================
	// Clocking
	// ==========================================================
	clock_enables #(
		.CE_DIV_W (CE_DIV_W)
	) u_clock_enables (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.turbo_sel (turbo_sel),
		.ce_cpu    (ce_cpu)
	);

	// ==========================================================
	// Port writes and paging
	// ==========================================================
	io_decode u_io_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine_mode (machine_mode),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.iorq         (iorq),
		.wr           (wr),
		.m1           (m1),
		.bus          (io_bus.source)
	);

	page_regs u_page_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (io_bus.pager),
		.map     (paging.source)
	);

	mem_map u_mem_map (
		.mreq     (mreq),
		.wr       (wr),
		.addr     (addr),
		.map      (paging.sink),
		.mem_addr (mem_addr),
		.mem_we   (mem_we)
	);

	// Shadow screen select for the video side
	assign scr_page = paging.scr_page;

	// ==========================================================
	// ULA port and sound
	// ==========================================================
	ula_port_dac #(
		.DAC_W (DAC_W)
	) u_ula_port_dac (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (io_bus.ula),
		.tape_in      (tape_in),
		.border_color (border_color),
		.audio        (audio)
	);

endmodule

`default_nettype wire

// File: hw/zx_pkg.sv
`default_nettype none

package zx_pkg;

	// ==========================================================
	// CPU bus
	// ==========================================================
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// ==========================================================
	// Physical memory
	// ==========================================================
	// Offset inside one 16K bank
	localparam int OFFSET_W = 14;
	// RAM banks 0 to 7, ROM banks from ROM_BANK_BASE upward
	localparam int BANK_W        = 4;
	localparam int ROM_BANK_BASE = 8;

	// ==========================================================
	// I/O ports
	// ==========================================================
	// Only a few address bits take part in the decode
	localparam logic [7:0]        PORT_FE   = 8'hFE;
	localparam logic [ADDR_W-1:0] PORT_7FFD = 16'h7FFD;
	localparam logic [ADDR_W-1:0] PORT_1FFD = 16'h1FFD;

	// ==========================================================
	// Machine modes
	// ==========================================================
	localparam int MODE_W = 2;
	localparam logic [MODE_W-1:0] MODE_48    = 2'd0;
	localparam logic [MODE_W-1:0] MODE_128   = 2'd1;
	localparam logic [MODE_W-1:0] MODE_PLUS3 = 2'd2;

	// Turbo select that runs the CPU at full clk_sys rate
	localparam int TURBO_MAX = 4;

endpackage

`default_nettype wire

// File: vlog.f
hw/zx_pkg.sv
hw/io_bus_if.sv
hw/paging_if.sv
hw/clock_enables.sv
hw/io_decode.sv
hw/page_regs.sv
hw/mem_map.sv
hw/ula_port_dac.sv
hw/zx_core_top.sv
bench/tb_zx_core.sv
